/* design/stap_pkg.sv */
// sTAP shared definitions
// IR geometry, capture pattern, device id, TAP states and opcodes

package stap_pkg;

   // ------------------------------------------------------------------------
   // instruction register
   // ------------------------------------------------------------------------
   localparam int IR_WIDTH = 4;

   // loaded at Capture-IR, LSB pair 01 as 1149.1 requires
   localparam logic [IR_WIDTH-1:0] IR_CAPTURE = 4'b0001;

   // device identifier, bit 0 is always 1
   localparam logic [31:0] IDCODE_VALUE = 32'h1B5A_70C3;

   // ------------------------------------------------------------------------
   // TAP controller states
   // ------------------------------------------------------------------------
   typedef enum logic [3:0] {
      ST_TLR    = 4'h0,
      ST_RTI    = 4'h1,
      ST_SEL_DR = 4'h2,
      ST_CAP_DR = 4'h3,
      ST_SH_DR  = 4'h4,
      ST_EX1_DR = 4'h5,
      ST_PAU_DR = 4'h6,
      ST_EX2_DR = 4'h7,
      ST_UPD_DR = 4'h8,
      ST_SEL_IR = 4'h9,
      ST_CAP_IR = 4'hA,
      ST_SH_IR  = 4'hB,
      ST_EX1_IR = 4'hC,
      ST_PAU_IR = 4'hD,
      ST_EX2_IR = 4'hE,
      ST_UPD_IR = 4'hF
   } tap_state_e;

   // opcodes; remote register k sits at OP_RTDR0 + k
   typedef enum logic [IR_WIDTH-1:0] {
      OP_IDCODE = 4'h1,
      OP_RTDR0  = 4'h8,
      OP_BYPASS = 4'hF
   } stap_opcode_e;

endpackage

/* design/tap_ctrl_if.sv */
// TAP control bundle
// carries state strobes and tdi from the controller to IR and DR bank

`timescale 1ns/1ps

interface tap_ctrl_if (
   input logic tck,
   input logic arst_n
);

   logic tdi;
   // dr side strobes
   logic capture_dr;
   logic shift_dr;
   logic update_dr;
   // ir side strobes
   logic capture_ir;
   logic shift_ir;
   logic update_ir;
   // controller sits in Test-Logic-Reset
   logic tlr;

   modport ctrl (
      input  tck, arst_n,
      output capture_dr, shift_dr, update_dr,
      output capture_ir, shift_ir, update_ir, tlr
   );

   modport ir (
      input tck, arst_n, tdi,
      input capture_ir, shift_ir, update_ir, tlr
   );

   modport dr (
      input tck, arst_n, tdi,
      input capture_dr, shift_dr, update_dr
   );

endinterface

/* design/tap_fsm.sv */
// TAP controller
// 16-state 1149.1 state machine stepped by tms on rising tck,
// decodes the current state into one-cycle control strobes

`timescale 1ns/1ps

module tap_fsm
   import stap_pkg::*;
(
   tap_ctrl_if.ctrl ctrl,
   input  logic     tms,
   output logic     shift_ir_q,
   output logic     shift_dr_q
);

   tap_state_e state;
   tap_state_e state_nxt;

   // ------------------------------------------------------------------------
   // next-state table
   // ------------------------------------------------------------------------
   always_comb
   begin
      case (state)
         ST_TLR    : state_nxt = tms ? ST_TLR    : ST_RTI;
         ST_RTI    : state_nxt = tms ? ST_SEL_DR : ST_RTI;
         ST_SEL_DR : state_nxt = tms ? ST_SEL_IR : ST_CAP_DR;
         ST_CAP_DR : state_nxt = tms ? ST_EX1_DR : ST_SH_DR;
         ST_SH_DR  : state_nxt = tms ? ST_EX1_DR : ST_SH_DR;
         ST_EX1_DR : state_nxt = tms ? ST_UPD_DR : ST_PAU_DR;
         ST_PAU_DR : state_nxt = tms ? ST_EX2_DR : ST_PAU_DR;
         ST_EX2_DR : state_nxt = tms ? ST_UPD_DR : ST_SH_DR;
         ST_UPD_DR : state_nxt = tms ? ST_SEL_DR : ST_RTI;
         // ir column mirrors the dr column
         ST_SEL_IR : state_nxt = tms ? ST_TLR    : ST_CAP_IR;
         ST_CAP_IR : state_nxt = tms ? ST_EX1_IR : ST_SH_IR;
         ST_SH_IR  : state_nxt = tms ? ST_EX1_IR : ST_SH_IR;
         ST_EX1_IR : state_nxt = tms ? ST_UPD_IR : ST_PAU_IR;
         ST_PAU_IR : state_nxt = tms ? ST_EX2_IR : ST_PAU_IR;
         ST_EX2_IR : state_nxt = tms ? ST_UPD_IR : ST_SH_IR;
         ST_UPD_IR : state_nxt = tms ? ST_SEL_DR : ST_RTI;
         default   : state_nxt = ST_TLR;
      endcase
   end

   // one transition per rising edge
   always_ff @(posedge ctrl.tck or negedge ctrl.arst_n)
   begin
      if (!ctrl.arst_n)
      begin
         state <= ST_TLR;
      end
      else
      begin
         state <= state_nxt;
      end
   end

   // ------------------------------------------------------------------------
   // state decode, each strobe lives for exactly one state
   // ------------------------------------------------------------------------
   assign ctrl.capture_dr = (state == ST_CAP_DR);
   assign ctrl.shift_dr   = (state == ST_SH_DR);
   assign ctrl.update_dr  = (state == ST_UPD_DR);
   assign ctrl.capture_ir = (state == ST_CAP_IR);
   assign ctrl.shift_ir   = (state == ST_SH_IR);
   assign ctrl.update_ir  = (state == ST_UPD_IR);
   assign ctrl.tlr        = (state == ST_TLR);

   // separate copies for the tdo combiner
   assign shift_ir_q = (state == ST_SH_IR);
   assign shift_dr_q = (state == ST_SH_DR);

endmodule

/* design/tap_ir.sv */
// instruction register
// capture pattern, LSB-first shift, update into the opcode register,
// and one-hot decode of the opcode into data register selects

`timescale 1ns/1ps

module tap_ir
   import stap_pkg::*;
#(
   parameter int NUM_RTDR = 3
)(
   tap_ctrl_if.ir            ctrl,
   output logic [NUM_RTDR+1:0] dr_select,
   output logic              ir_tdo
);

   logic [IR_WIDTH-1:0] ir_chain;
   stap_opcode_e        ir_op;
   logic [NUM_RTDR-1:0] rtdr_hit;
   logic                idcode_hit;

   // shift chain, only meaningful between capture and update
   always_ff @(posedge ctrl.tck)
   begin
      if (ctrl.capture_ir)
      begin
         ir_chain <= IR_CAPTURE;
      end
      else if (ctrl.shift_ir)
      begin
         ir_chain <= {ctrl.tdi, ir_chain[IR_WIDTH-1:1]};
      end
   end

   assign ir_tdo = ir_chain[0];

   // opcode falls back to IDCODE in Test-Logic-Reset
   always_ff @(posedge ctrl.tck or negedge ctrl.arst_n)
   begin
      if (!ctrl.arst_n)
      begin
         ir_op <= OP_IDCODE;
      end
      else if (ctrl.tlr)
      begin
         ir_op <= OP_IDCODE;
      end
      else if (ctrl.update_ir)
      begin
         ir_op <= stap_opcode_e'(ir_chain);
      end
   end

   // ------------------------------------------------------------------------
   // opcode decode
   // ------------------------------------------------------------------------
   for (genvar k = 0; k < NUM_RTDR; k++)
   begin : g_rtdr_dec
      localparam logic [IR_WIDTH-1:0] RTDR_CODE = IR_WIDTH'(OP_RTDR0 + k);
      assign rtdr_hit[k] = (ir_op == RTDR_CODE);
   end

   assign idcode_hit = (ir_op == OP_IDCODE);

   // layout: remote registers low, then IDCODE, then BYPASS on top
   assign dr_select[NUM_RTDR-1:0] = rtdr_hit;
   assign dr_select[NUM_RTDR]     = idcode_hit;
   // OP_BYPASS and every unmapped code land here
   assign dr_select[NUM_RTDR+1]   = ~(|rtdr_hit) & ~idcode_hit;

endmodule

/* design/rtdr_cell.sv */
// remote test data register
// shift chain plus shadow, shadow looped back as capture data

`timescale 1ns/1ps

module rtdr_cell #(
   parameter int RTDR_WIDTH = 32
)(
   input  logic tck,
   input  logic arst_n,
   input  logic tdi,
   input  logic select,
   input  logic capture,
   input  logic shift,
   input  logic update,
   output logic tdo
);

   logic [RTDR_WIDTH-1:0] shift_reg;
   logic [RTDR_WIDTH-1:0] shadow_reg;

   // capture pulls the shadow back in, shift moves toward bit 0
   always_ff @(posedge tck)
   begin
      if (select & capture)
      begin
         shift_reg <= shadow_reg;
      end
      else if (select & shift)
      begin
         shift_reg <= {tdi, shift_reg[RTDR_WIDTH-1:1]};
      end
   end

   // shadow holds the last written value across scans
   always_ff @(posedge tck or negedge arst_n)
   begin
      if (!arst_n)
      begin
         shadow_reg <= '0;
      end
      else if (select & update)
      begin
         shadow_reg <= shift_reg;
      end
   end

   assign tdo = shift_reg[0];

endmodule

/* design/rtdr_bank.sv */
// data register bank
// NUM_RTDR remote registers plus IDCODE and BYPASS,
// selected one-hot by the IR decode; serial out is the selected LSB

`timescale 1ns/1ps

module rtdr_bank
   import stap_pkg::*;
#(
   parameter int NUM_RTDR   = 3,
   parameter int RTDR_WIDTH = 32
)(
   tap_ctrl_if.dr             ctrl,
   input  logic [NUM_RTDR+1:0] dr_select,
   output logic               dr_tdo
);

   logic [NUM_RTDR+1:0] tdo_vec;
   logic [31:0]         idcode_reg;
   logic                bypass_reg;

   // ------------------------------------------------------------------------
   // remote registers
   // ------------------------------------------------------------------------
   for (genvar k = 0; k < NUM_RTDR; k++)
   begin : g_rtdr
      rtdr_cell #(
         .RTDR_WIDTH (RTDR_WIDTH)
      ) u_rtdr_cell (
         .tck     (ctrl.tck),
         .arst_n  (ctrl.arst_n),
         .tdi     (ctrl.tdi),
         .select  (dr_select[k]),
         .capture (ctrl.capture_dr),
         .shift   (ctrl.shift_dr),
         .update  (ctrl.update_dr),
         .tdo     (tdo_vec[k])
      );
   end

   // ------------------------------------------------------------------------
   // IDCODE and BYPASS
   // ------------------------------------------------------------------------
   // idcode is capture and shift only, nothing to update
   always_ff @(posedge ctrl.tck)
   begin
      if (dr_select[NUM_RTDR] & ctrl.capture_dr)
      begin
         idcode_reg <= IDCODE_VALUE;
      end
      else if (dr_select[NUM_RTDR] & ctrl.shift_dr)
      begin
         idcode_reg <= {ctrl.tdi, idcode_reg[31:1]};
      end
   end

   // single stage, captures 0
   always_ff @(posedge ctrl.tck)
   begin
      if (dr_select[NUM_RTDR+1] & ctrl.capture_dr)
      begin
         bypass_reg <= 1'b0;
      end
      else if (dr_select[NUM_RTDR+1] & ctrl.shift_dr)
      begin
         bypass_reg <= ctrl.tdi;
      end
   end

   assign tdo_vec[NUM_RTDR]   = idcode_reg[0];
   assign tdo_vec[NUM_RTDR+1] = bypass_reg;

   // select is one-hot so a masked OR picks the chain
   assign dr_tdo = |(tdo_vec & dr_select);

endmodule

/* design/tdo_mux.sv */
// TDO combiner
// picks IR or DR serial data in the shift states and retimes it
// on the falling tck edge, 0 outside shift states

`timescale 1ns/1ps

module tdo_mux (
   input  logic tck,
   input  logic arst_n,
   input  logic ir_tdo,
   input  logic dr_tdo,
   input  logic shift_ir,
   input  logic shift_dr,
   output logic tdo
);

   logic tdo_nxt;

   always_comb
   begin
      if (shift_ir)
      begin
         tdo_nxt = ir_tdo;
      end
      else if (shift_dr)
      begin
         tdo_nxt = dr_tdo;
      end
      else
      begin
         tdo_nxt = 1'b0;
      end
   end

   // negedge retime, half a cycle ahead of the next capture
   always_ff @(negedge tck or negedge arst_n)
   begin
      if (!arst_n)
      begin
         tdo <= 1'b0;
      end
      else
      begin
         tdo <= tdo_nxt;
      end
   end

endmodule

/* design/stap_top.sv */
// sTAP top level
// TAP controller, instruction register, data register bank and
// tdo retiming behind plain JTAG pins

`timescale 1ns/1ps

module stap_top #(
   parameter int NUM_RTDR   = 3,
   parameter int RTDR_WIDTH = 32
)(
   input  logic tck,
   input  logic arst_n,
   input  logic tms,
   input  logic tdi,
   output logic tdo
);

   logic [NUM_RTDR+1:0] dr_select;
   logic                ir_tdo;
   logic                dr_tdo;
   logic                shift_ir;
   logic                shift_dr;

   tap_ctrl_if ctrl_if (
      .tck    (tck),
      .arst_n (arst_n)
   );

   // tdi fans out to IR and DR chains through the bundle
   assign ctrl_if.tdi = tdi;

   tap_fsm u_tap_fsm (
      .ctrl       (ctrl_if.ctrl),
      .tms        (tms),
      .shift_ir_q (shift_ir),
      .shift_dr_q (shift_dr)
   );

   tap_ir #(
      .NUM_RTDR (NUM_RTDR)
   ) u_tap_ir (
      .ctrl      (ctrl_if.ir),
      .dr_select (dr_select),
      .ir_tdo    (ir_tdo)
   );

   rtdr_bank #(
      .NUM_RTDR   (NUM_RTDR),
      .RTDR_WIDTH (RTDR_WIDTH)
   ) u_rtdr_bank (
      .ctrl      (ctrl_if.dr),
      .dr_select (dr_select),
      .dr_tdo    (dr_tdo)
   );

   tdo_mux u_tdo_mux (
      .tck      (tck),
      .arst_n   (arst_n),
      .ir_tdo   (ir_tdo),
      .dr_tdo   (dr_tdo),
      .shift_ir (shift_ir),
      .shift_dr (shift_dr),
      .tdo      (tdo)
   );

endmodule

/* sim/stap_assertions.sv */
// TAP assertions
// tdo idle after shift, tms reset path, strobe entry conditions

`timescale 1ns/1ps

module stap_assertions (
   input logic tck,
   input logic arst_n,
   input logic tms,
   input logic tdo,
   input logic shift_ir,
   input logic shift_dr,
   input logic tlr,
   input logic capture_dr,
   input logic update_dr,
   input logic capture_ir,
   input logic update_ir
);

   int fail_count;

   initial fail_count = 0;

   // tdo drops to 0 one falling edge after leaving shift
   a_tdo_idle: assert property (@(negedge tck) disable iff (!arst_n)
      $fell(shift_ir | shift_dr) |=> (tdo == 1'b0))
   else
   begin
      fail_count = fail_count + 1;
      $error("tdo not 0 one falling edge after a shift state");
   end

   // five tms-high edges from anywhere land in Test-Logic-Reset
   a_tms_reset: assert property (@(posedge tck) disable iff (!arst_n)
      tms [*5] |=> tlr)
   else
   begin
      fail_count = fail_count + 1;
      $error("five tms-high cycles did not reach Test-Logic-Reset");
   end

   // capture is entered on tms low, update on tms high
   a_strobe_entry: assert property (@(posedge tck) disable iff (!arst_n)
      (capture_dr | capture_ir | update_dr | update_ir)
         |-> ($past(tms) == (update_dr | update_ir)))
   else
   begin
      fail_count = fail_count + 1;
      $error("capture or update strobe entered with the wrong tms value");
   end

endmodule

/* sim/stap_checker.sv */
// tdo checker
// collects tdo on rising tck inside the check window and compares
// the scan-out with the expected value when the window closes

`timescale 1ns/1ps

module stap_checker (
   input  logic        tck,
   input  logic        arst_n,
   input  logic        tdo,
   input  logic        check_en,
   input  logic [63:0] exp_data,
   input  int          exp_len,
   input  int          row_id,
   output int          pass_count,
   output int          fail_count
);

   logic [63:0] rx;
   logic [63:0] len_mask;
   int          nbits;
   logic        en_q;

   // only the scanned bits count
   assign len_mask = (exp_len >= 64) ? {64{1'b1}} : ((64'd1 << exp_len) - 64'd1);

   initial
   begin
      pass_count = 0;
      fail_count = 0;
   end

   always @(posedge tck or negedge arst_n)
   begin
      if (!arst_n)
      begin
         en_q  <= 1'b0;
         rx    <= '0;
         nbits <= 0;
      end
      else
      begin
         en_q <= check_en;
         if (check_en)
         begin
            // first bit of a window restarts the collection
            if (!en_q)
            begin
               rx    <= {63'd0, tdo};
               nbits <= 1;
            end
            else
            begin
               rx    <= rx | ({63'd0, tdo} << nbits);
               nbits <= nbits + 1;
            end
         end
         else if (en_q)
         begin
            // window just closed
            if (nbits != exp_len)
            begin
               $display("row %0d: checker saw %0d tdo samples but the scan had %0d bits",
                        row_id, nbits, exp_len);
               fail_count = fail_count + 1;
            end
            else if ((rx & len_mask) !== (exp_data & len_mask))
            begin
               $display("MISMATCH at %0t: row %0d expected %h received %h",
                        $time, row_id, exp_data & len_mask, rx & len_mask);
               fail_count = fail_count + 1;
            end
            else
            begin
               $display("row %0d: %0d-bit scan ok, read %h", row_id, exp_len, rx & len_mask);
               pass_count = pass_count + 1;
            end
         end
      end
   end

endmodule

/* sim/stap_tb.sv */
// sTAP testbench
// drives the JTAG pins through a table of IR and DR scans,
// the checker compares tdo; watchdog bounds the run

`timescale 1ns/1ps

module stap_tb;

   localparam int TCK_PERIOD  = 40;
   localparam int NUM_RTDR    = 3;
   localparam int RTDR_WIDTH  = 32;
   localparam int NUM_ROWS    = 19;
   localparam int WATCHDOG_NS = 2 * NUM_ROWS * 80 * TCK_PERIOD;

   // row kinds
   localparam logic [1:0] KIND_IR  = 2'd0;
   localparam logic [1:0] KIND_DR  = 2'd1;
   localparam logic [1:0] KIND_TLR = 2'd2;

   typedef struct packed {
      logic [1:0]  kind;
      logic [7:0]  len;
      logic [63:0] din;
      logic [63:0] dout;
   } scan_row_t;

   logic        tck;
   logic        arst_n;
   logic        tms;
   logic        tdi;
   logic        tdo;
   logic        check_en;
   logic [63:0] exp_data;
   int          exp_len;
   int          row_id;
   int          pass_count;
   int          fail_count;
   scan_row_t   rows [NUM_ROWS];

   stap_top #(
      .NUM_RTDR   (NUM_RTDR),
      .RTDR_WIDTH (RTDR_WIDTH)
   ) DUT (
      .tck    (tck),
      .arst_n (arst_n),
      .tms    (tms),
      .tdi    (tdi),
      .tdo    (tdo)
   );

   stap_checker u_checker (
      .tck        (tck),
      .arst_n     (arst_n),
      .tdo        (tdo),
      .check_en   (check_en),
      .exp_data   (exp_data),
      .exp_len    (exp_len),
      .row_id     (row_id),
      .pass_count (pass_count),
      .fail_count (fail_count)
   );

   bind stap_top stap_assertions u_assert (
      .tck        (tck),
      .arst_n     (arst_n),
      .tms        (tms),
      .tdo        (tdo),
      .shift_ir   (shift_ir),
      .shift_dr   (shift_dr),
      .tlr        (ctrl_if.tlr),
      .capture_dr (ctrl_if.capture_dr),
      .update_dr  (ctrl_if.update_dr),
      .capture_ir (ctrl_if.capture_ir),
      .update_ir  (ctrl_if.update_ir)
   );

   initial
   begin
      tck = 1'b0;
      forever #(TCK_PERIOD / 2) tck = ~tck;
   end

   // --------------------------------------------------------------------------
   // scan table, shift-out bits listed LSB first as they leave tdo
   // --------------------------------------------------------------------------
   task automatic load_table();
      // IR resets to IDCODE
      rows[0]  = '{KIND_DR, 8'd32, 64'h0, {32'h0, stap_pkg::IDCODE_VALUE}};
      // bypass, then an unmapped code: 0 then din delayed one bit
      rows[1]  = '{KIND_IR, 8'd4, 64'hF, {60'h0, stap_pkg::IR_CAPTURE}};
      rows[2]  = '{KIND_DR, 8'd8, 64'hA5, 64'h4A};
      rows[3]  = '{KIND_IR, 8'd4, 64'h5, {60'h0, stap_pkg::IR_CAPTURE}};
      rows[4]  = '{KIND_DR, 8'd12, 64'h3C9, 64'h792};
      // remote register 0, write then read back
      rows[5]  = '{KIND_IR, 8'd4, 64'h8, {60'h0, stap_pkg::IR_CAPTURE}};
      rows[6]  = '{KIND_DR, 8'd32, 64'hDEAD_BEEF, 64'h0};
      rows[7]  = '{KIND_DR, 8'd32, 64'h1234_5678, 64'hDEAD_BEEF};
      // remote register 1
      rows[8]  = '{KIND_IR, 8'd4, 64'h9, {60'h0, stap_pkg::IR_CAPTURE}};
      rows[9]  = '{KIND_DR, 8'd32, 64'hCAFE_F00D, 64'h0};
      // 8-bit IR scan, capture in low nibble, first din nibble above it
      rows[10] = '{KIND_IR, 8'd8, 64'h8F, 64'hF1};
      rows[11] = '{KIND_DR, 8'd32, 64'h1234_5678, 64'h1234_5678};
      // back through Test-Logic-Reset
      rows[12] = '{KIND_TLR, 8'd0, 64'h0, 64'h0};
      rows[13] = '{KIND_DR, 8'd32, 64'h0, {32'h0, stap_pkg::IDCODE_VALUE}};
      rows[14] = '{KIND_IR, 8'd4, 64'h9, {60'h0, stap_pkg::IR_CAPTURE}};
      rows[15] = '{KIND_DR, 8'd32, 64'h0F0F_0F0F, 64'hCAFE_F00D};
      // remote register 2 untouched so far
      rows[16] = '{KIND_IR, 8'd4, 64'hA, {60'h0, stap_pkg::IR_CAPTURE}};
      rows[17] = '{KIND_DR, 8'd32, 64'h5555_AAAA, 64'h0};
      rows[18] = '{KIND_DR, 8'd32, 64'h0, 64'h5555_AAAA};
   endtask

   // one tck cycle, pins change on the falling edge
   task automatic tap_step(input logic tms_v, input logic tdi_v);
      @(negedge tck);
      tms = tms_v;
      tdi = tdi_v;
   endtask

   // Run-Test/Idle to Run-Test/Idle through one IR or DR scan
   task automatic run_scan(input logic is_ir, input int len, input logic [63:0] din,
                           input logic [63:0] dout, input int row);
      tap_step(1'b1, 1'b0);
      if (is_ir)
      begin
         tap_step(1'b1, 1'b0);
      end
      // capture, then into shift
      tap_step(1'b0, 1'b0);
      tap_step(1'b0, 1'b0);
      for (int i = 0; i < len; i++)
      begin
         @(negedge tck);
         tms = (i == len - 1);
         tdi = din[i];
         if (i == 0)
         begin
            exp_data = dout;
            exp_len  = len;
            row_id   = row;
            check_en = 1'b1;
         end
      end
      // Exit1 to Update, window closes here
      @(negedge tck);
      check_en = 1'b0;
      tms      = 1'b1;
      tdi      = 1'b0;
      tap_step(1'b0, 1'b0);
   endtask

   // five tms-high cycles, then park in Run-Test/Idle
   task automatic reset_by_tms();
      repeat (5) tap_step(1'b1, 1'b0);
      tap_step(1'b0, 1'b0);
   endtask

   initial
   begin : main
      tms      = 1'b1;
      tdi      = 1'b0;
      arst_n   = 1'b0;
      check_en = 1'b0;
      exp_data = '0;
      exp_len  = 0;
      row_id   = 0;
      load_table();
      repeat (10) @(negedge tck);
      arst_n = 1'b1;
      tap_step(1'b0, 1'b0);
      for (int r = 0; r < NUM_ROWS; r++)
      begin
         if (rows[r].kind == KIND_TLR)
         begin
            reset_by_tms();
            $display("row %0d: five tms-high cycles done", r);
         end
         else
         begin
            run_scan(rows[r].kind == KIND_IR, int'(rows[r].len), rows[r].din,
                     rows[r].dout, r);
         end
      end
      // idle cycles so the last compare lands
      tap_step(1'b0, 1'b0);
      tap_step(1'b0, 1'b0);
      $display("scans passed %0d, failed %0d, assertion failures %0d",
               pass_count, fail_count, DUT.u_assert.fail_count);
      if (fail_count == 0 && pass_count == NUM_ROWS - 1 && DUT.u_assert.fail_count == 0)
      begin
         $display("=== PASS ===");
      end
      else
      begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // --------------------------------------------------------------------------
   // watchdog
   // --------------------------------------------------------------------------
   initial
   begin : watchdog
      #(WATCHDOG_NS * 1ns);
      $display("scan sequence did not finish within %0d ns", WATCHDOG_NS);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

/* vlog.f */
design/stap_pkg.sv
design/tap_ctrl_if.sv
design/tap_fsm.sv
design/tap_ir.sv
design/rtdr_cell.sv
design/rtdr_bank.sv
design/tdo_mux.sv
design/stap_top.sv
sim/stap_assertions.sv
sim/stap_checker.sv
sim/stap_tb.sv

/* Makefile */
SIM      ?= verilator
SIMFLAGS ?= --binary --timing --assert
TOP      ?= stap_tb
FILELIST ?= vlog.f
RUNARGS  ?= +verilator+error+limit+100

SOURCES := $(shell cat $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUNARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir
